// ==== rtl/rvseed_pkg.sv ====
package rvseed_pkg;

    localparam int XLEN           = 64;
    localparam int INST_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_RW     = 7'b0111011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_IW     = 7'b0011011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_LD      = 3'b011;
    localparam logic [2:0] F3_LBU     = 3'b100;
    localparam logic [2:0] F3_SH      = 3'b001;
    localparam logic [2:0] F3_SD      = 3'b011;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_JALR    = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub

    localparam logic [INST_WIDTH-1:0] INST_EBREAK = 32'h0010_0073;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_SLL, ALU_SRL, ALU_SLTU} alu_op_e;
    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;
    typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_PC_IMM, SRC_PC_FOUR} alu_src_e;
    typedef enum logic [2:0] {WB_ALU, WB_LW, WB_LD, WB_LBU} wb_sel_e;

endpackage

// ==== rtl/ctrl.sv ====
`timescale 1ns/100ps

module ctrl
    import rvseed_pkg::*;
(
    input  logic [INST_WIDTH-1:0]     inst,
    output logic                      reg_wen,
    output logic [REG_ADDR_WIDTH-1:0] reg_waddr,
    output logic [REG_ADDR_WIDTH-1:0] reg1_raddr,
    output logic [REG_ADDR_WIDTH-1:0] reg2_raddr,
    output imm_sel_e                  imm_sel,
    output alu_op_e                   alu_op,
    output alu_src_e                  alu_src,
    output logic                      word_op,
    output logic                      branch,
    output logic                      branch_ne,
    output logic                      jump,
    output logic                      jalr,
    output logic                      mem_wen,
    output logic [7:0]                mem_wmask,
    output wb_sel_e                   wb_sel,
    output logic                      ebreak,
    output logic                      illegal
);

    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [REG_ADDR_WIDTH-1:0] rs1;
    logic [REG_ADDR_WIDTH-1:0] rs2;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    always_comb begin
        reg_wen    = 1'b0;
        reg_waddr  = '0;
        reg1_raddr = '0; // unused reads go to x0
        reg2_raddr = '0;
        imm_sel    = IMM_I;
        alu_op     = ALU_ADD;
        alu_src    = SRC_REG;
        word_op    = 1'b0;
        branch     = 1'b0;
        branch_ne  = 1'b0;
        jump       = 1'b0;
        jalr       = 1'b0;
        mem_wen    = 1'b0;
        mem_wmask  = 8'h00;
        wb_sel     = WB_ALU;
        ebreak     = 1'b0;
        illegal    = 1'b0;
        case (opcode)
            OP_R, OP_RW: begin
                reg_wen    = 1'b1;
                reg_waddr  = rd;
                reg1_raddr = rs1;
                reg2_raddr = rs2;
                word_op    = (opcode == OP_RW);
                if (funct3 == F3_ADD_SUB && funct7 == F7_BASE) alu_op = ALU_ADD;
                else if (funct3 == F3_ADD_SUB && funct7 == F7_ALT && !word_op) alu_op = ALU_SUB;
                else if (funct3 == F3_AND && funct7 == F7_BASE && !word_op) alu_op = ALU_AND;
                else if (funct3 == F3_SLL && funct7 == F7_BASE && word_op) alu_op = ALU_SLL;
                else illegal = 1'b1;
            end
            OP_I, OP_IW: begin
                reg_wen    = 1'b1;
                reg_waddr  = rd;
                reg1_raddr = rs1;
                alu_src    = SRC_IMM;
                word_op    = (opcode == OP_IW);
                if (funct3 == F3_ADD_SUB) alu_op = ALU_ADD;
                else if (funct3 == F3_AND && !word_op) alu_op = ALU_AND;
                else if (funct3 == F3_SLTU && !word_op) alu_op = ALU_SLTU;
                else if (funct3 == F3_SRL && inst[31:26] == 6'b0 && !word_op) alu_op = ALU_SRL;
                else illegal = 1'b1; // srai lands here
            end
            OP_LOAD: begin
                reg_wen    = 1'b1;
                reg_waddr  = rd;
                reg1_raddr = rs1;
                alu_src    = SRC_IMM;
                case (funct3)
                    F3_LW:   wb_sel = WB_LW;
                    F3_LD:   wb_sel = WB_LD;
                    F3_LBU:  wb_sel = WB_LBU;
                    default: illegal = 1'b1;
                endcase
            end
            OP_STORE: begin
                reg1_raddr = rs1;
                reg2_raddr = rs2;
                imm_sel    = IMM_S;
                alu_src    = SRC_IMM;
                mem_wen    = 1'b1;
                case (funct3)
                    F3_SD:   mem_wmask = 8'hff;
                    F3_SH:   mem_wmask = 8'h03;
                    default: illegal = 1'b1;
                endcase
            end
            OP_BRANCH: begin
                reg1_raddr = rs1;
                reg2_raddr = rs2;
                imm_sel    = IMM_B;
                alu_op     = ALU_SUB; // compare via zero flag
                branch     = 1'b1;
                case (funct3)
                    F3_BEQ:  branch_ne = 1'b0;
                    F3_BNE:  branch_ne = 1'b1;
                    default: illegal = 1'b1;
                endcase
            end
            OP_JAL: begin
                reg_wen   = 1'b1;
                reg_waddr = rd;
                imm_sel   = IMM_J;
                alu_src   = SRC_PC_FOUR; // link value
                jump      = 1'b1;
            end
            OP_JALR: begin
                reg_wen    = 1'b1;
                reg_waddr  = rd;
                reg1_raddr = rs1;
                alu_src    = SRC_PC_FOUR;
                jump       = 1'b1;
                jalr       = 1'b1;
                illegal    = (funct3 != F3_JALR);
            end
            OP_LUI: begin
                reg_wen   = 1'b1;
                reg_waddr = rd;
                imm_sel   = IMM_U;
                alu_src   = SRC_IMM; // x0 + imm
            end
            OP_AUIPC: begin
                reg_wen   = 1'b1;
                reg_waddr = rd;
                imm_sel   = IMM_U;
                alu_src   = SRC_PC_IMM;
            end
            OP_SYSTEM: begin
                ebreak  = (inst == INST_EBREAK);
                illegal = (inst != INST_EBREAK);
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            reg_wen = 1'b0;
            mem_wen = 1'b0;
            branch  = 1'b0;
            jump    = 1'b0;
        end
        assert (!(reg_wen && mem_wen))
            else $error("ctrl: register and memory write both enabled");
    end

endmodule

// ==== rtl/imm_gen.sv ====
`timescale 1ns/100ps

module imm_gen
    import rvseed_pkg::*;
(
    input  logic [INST_WIDTH-1:0] inst,
    input  imm_sel_e              imm_sel,
    output logic [XLEN-1:0]       imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_sel)
            IMM_I:   imm = {{52{sign}}, inst[31:20]};
            IMM_S:   imm = {{52{sign}}, inst[31:25], inst[11:7]};
            IMM_B:   imm = {{52{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_U:   imm = {{32{sign}}, inst[31:12], 12'b0};
            IMM_J:   imm = {{44{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/100ps

module alu
    import rvseed_pkg::*;
(
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_e         alu_op,
    input  logic            word_op,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    logic [5:0]      shamt;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] raw;

    assign shamt = word_op ? {1'b0, b[4:0]} : b[5:0];
    assign diff  = a - b;
    assign zero  = (diff == '0);

    always_comb begin
        case (alu_op)
            ALU_ADD:  raw = a + b;
            ALU_SUB:  raw = diff;
            ALU_AND:  raw = a & b;
            ALU_SLL:  raw = a << shamt; // low word is correct for sllw
            ALU_SRL:  raw = word_op ? ({32'b0, a[31:0]} >> shamt) : (a >> shamt);
            ALU_SLTU: raw = {{(XLEN-1){1'b0}}, (a < b)};
            default:  raw = '0;
        endcase
    end

    assign result = word_op ? {{32{raw[31]}}, raw[31:0]} : raw;

    // decoder always resolves to a known op, even on an X instruction
    always_comb begin
        assert final (!$isunknown(alu_op))
            else $error("alu: unknown alu_op");
    end

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/100ps

module regfile
    import rvseed_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wen,
    input  logic [REG_ADDR_WIDTH-1:0] waddr,
    input  logic [XLEN-1:0]           wdata,
    input  logic [REG_ADDR_WIDTH-1:0] raddr1,
    input  logic [REG_ADDR_WIDTH-1:0] raddr2,
    output logic [XLEN-1:0]           rdata1,
    output logic [XLEN-1:0]           rdata2
);

    localparam int REG_COUNT = 2 ** REG_ADDR_WIDTH;

    logic [XLEN-1:0] regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) regs[i] <= '0;
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1]; // old value on same-cycle write
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n) wen |=> regs[0] == '0);

endmodule

// ==== rtl/rvseed_core.sv ====
`timescale 1ns/100ps

module rvseed_core
    import rvseed_pkg::*;
#(
    parameter logic [XLEN-1:0] reset_pc = '0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic [XLEN-1:0]       imem_addr,
    input  logic [INST_WIDTH-1:0] imem_rdata,
    output logic [XLEN-1:0]       dmem_addr,
    output logic [XLEN-1:0]       dmem_wdata,
    output logic [7:0]            dmem_wmask,
    output logic                  dmem_wen,
    input  logic [XLEN-1:0]       dmem_rdata,
    output logic                  halt,
    output logic                  illegal
);

    logic [XLEN-1:0]           pc;
    logic                      run;
    logic                      reg_wen;
    logic [REG_ADDR_WIDTH-1:0] reg_waddr;
    logic [REG_ADDR_WIDTH-1:0] reg1_raddr;
    logic [REG_ADDR_WIDTH-1:0] reg2_raddr;
    imm_sel_e                  imm_sel;
    alu_op_e                   alu_op;
    alu_src_e                  alu_src;
    wb_sel_e                   wb_sel;
    logic                      word_op;
    logic                      branch;
    logic                      branch_ne;
    logic                      jump;
    logic                      jalr;
    logic                      mem_wen;
    logic [7:0]                mem_wmask;
    logic                      dec_ebreak;
    logic                      dec_illegal;
    logic [XLEN-1:0]           imm;
    logic [XLEN-1:0]           rs1_data;
    logic [XLEN-1:0]           rs2_data;
    logic [XLEN-1:0]           op_a;
    logic [XLEN-1:0]           op_b;
    logic [XLEN-1:0]           alu_result;
    logic                      alu_zero;
    logic [XLEN-1:0]           target_sum;
    logic [XLEN-1:0]           next_pc;
    logic [2:0]                offset;
    logic [XLEN-1:0]           load_shifted;
    logic [XLEN-1:0]           wb_data;

    assign run       = !halt && !illegal;
    assign imem_addr = pc;

    ctrl u_ctrl (
        .inst(imem_rdata), .reg_wen(reg_wen), .reg_waddr(reg_waddr),
        .reg1_raddr(reg1_raddr), .reg2_raddr(reg2_raddr), .imm_sel(imm_sel),
        .alu_op(alu_op), .alu_src(alu_src), .word_op(word_op), .branch(branch),
        .branch_ne(branch_ne), .jump(jump), .jalr(jalr), .mem_wen(mem_wen),
        .mem_wmask(mem_wmask), .wb_sel(wb_sel), .ebreak(dec_ebreak), .illegal(dec_illegal)
    );

    imm_gen u_imm_gen (.inst(imem_rdata), .imm_sel(imm_sel), .imm(imm));

    regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .wen(reg_wen && run), .waddr(reg_waddr), .wdata(wb_data),
        .raddr1(reg1_raddr), .raddr2(reg2_raddr), .rdata1(rs1_data), .rdata2(rs2_data)
    );

    always_comb begin
        case (alu_src)
            SRC_IMM:     {op_a, op_b} = {rs1_data, imm};
            SRC_PC_IMM:  {op_a, op_b} = {pc, imm};
            SRC_PC_FOUR: {op_a, op_b} = {pc, XLEN'(4)};
            default:     {op_a, op_b} = {rs1_data, rs2_data};
        endcase
    end

    alu u_alu (
        .a(op_a), .b(op_b), .alu_op(alu_op), .word_op(word_op),
        .result(alu_result), .zero(alu_zero)
    );

    // separate target adder, the alu is busy with the link value
    assign target_sum = (jalr ? rs1_data : pc) + imm;
    assign next_pc    = (jump || (branch && (alu_zero ^ branch_ne)))
                      ? {target_sum[XLEN-1:1], target_sum[0] & !jalr}
                      : pc + XLEN'(4);

    assign offset     = alu_result[2:0];
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_data << {offset, 3'b000};
    assign dmem_wmask = mem_wmask << offset;
    assign dmem_wen   = mem_wen && run;

    assign load_shifted = dmem_rdata >> {offset, 3'b000};

    always_comb begin
        case (wb_sel)
            WB_LW:   wb_data = {{32{load_shifted[31]}}, load_shifted[31:0]};
            WB_LD:   wb_data = dmem_rdata;
            WB_LBU:  wb_data = {56'b0, load_shifted[7:0]};
            default: wb_data = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= reset_pc;
            halt    <= 1'b0;
            illegal <= 1'b0;
        end else if (run) begin
            halt    <= dec_ebreak; // sticky, run drops once set
            illegal <= dec_illegal;
            if (!dec_ebreak && !dec_illegal) pc <= next_pc;
        end
    end

endmodule

// ==== tests/tb_rvseed_core.sv ====
`timescale 1ns/100ps

module tb_rvseed_core;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 5;
    localparam int MAX_CYCLES = 100;
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 64;

    localparam logic [6:0]  OPC_R     = 7'b0110011;
    localparam logic [6:0]  OPC_RW    = 7'b0111011;
    localparam logic [6:0]  OPC_I     = 7'b0010011;
    localparam logic [6:0]  OPC_IW    = 7'b0011011;
    localparam logic [6:0]  OPC_LOAD  = 7'b0000011;
    localparam logic [6:0]  OPC_LUI   = 7'b0110111;
    localparam logic [6:0]  OPC_AUIPC = 7'b0010111;
    localparam logic [6:0]  OPC_JALR  = 7'b1100111;
    localparam logic [31:0] EBREAK    = 32'h0010_0073;

    logic        clk;
    logic        rst_n;
    logic [63:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [63:0] dmem_addr;
    logic [63:0] dmem_wdata;
    logic [7:0]  dmem_wmask;
    logic        dmem_wen;
    logic [63:0] dmem_rdata;
    logic        halt;
    logic        illegal;

    logic [31:0] imem [IMEM_WORDS];
    logic [63:0] dmem [DMEM_WORDS];
    logic [63:0] dmem_init [DMEM_WORDS];
    logic [31:0] prog [$];
    int          errors;
    int          checks;

    rvseed_core #(.reset_pc(64'h0)) dut (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_wmask(dmem_wmask),
        .dmem_wen(dmem_wen), .dmem_rdata(dmem_rdata), .halt(halt), .illegal(illegal)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[8:3]];

    always @(posedge clk) begin
        if (!rst_n) begin
            dmem <= dmem_init; // preload while the core is held
        end else if (dmem_wen) begin
            for (int b = 0; b < 8; b++) begin
                if (dmem_wmask[b]) dmem[dmem_addr[8:3]][8*b +: 8] <= dmem_wdata[8*b +: 8];
            end
        end
    end

    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd, input logic [6:0] op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input int rd,
                                           input logic [6:0] op);
        return {imm, rd[4:0], op};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [63:0] imm_to_64(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic logic [63:0] word_to_64(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // opcode 0 decodes as illegal
    function automatic logic [31:0] unused_inst(input int i);
        return {i[24:0], 7'h00};
    endfunction

    function automatic logic [63:0] fill_word(input int i);
        return {16'hf11e, i[15:0], ~i[15:0], i[7:0], ~i[7:0]};
    endfunction

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("** Error: %s = %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) $display("%s: pass", name);
        else $display("%s: %0d error(s)", name, errors - errors_before);
    endtask

    task automatic prepare_memories();
        prog.delete();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem_init[i] = fill_word(i);
        end
    endtask

    // lui + addi, returns the register value they produce
    task automatic load_const(input int rd, input logic [31:0] value,
                              output logic [63:0] reg_value);
        logic [19:0] hi;
        logic [11:0] lo;
        lo = value[11:0];
        hi = value[31:12] + {19'b0, lo[11]};
        prog.push_back(u_type(hi, rd, OPC_LUI));
        prog.push_back(i_type(int'(lo), rd, 0, rd, OPC_I));
        reg_value = word_to_64({hi, 12'b0}) + imm_to_64(lo);
    endtask

    task automatic start_core();
        @(posedge clk);
        #2 rst_n = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : unused_inst(i);
        end
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!halt && !illegal && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!halt && !illegal) begin
            $display("program ran %0d cycles without reaching ebreak or illegal", cycles);
            errors++;
        end
    endtask

    task automatic arith_test();
        logic [63:0] a;
        logic [63:0] b;
        logic [11:0] k;
        logic [11:0] m;
        logic [63:0] exp_val [6];
        int          err0;
        err0 = errors;
        prepare_memories();
        load_const(1, $urandom(), a);
        load_const(2, $urandom(), b);
        k = 12'($urandom());
        m = 12'($urandom());
        prog.push_back(r_type(0, 2, 1, 0, 3, OPC_R));    // add
        prog.push_back(r_type(32, 2, 1, 0, 4, OPC_R));   // sub
        prog.push_back(r_type(0, 2, 1, 7, 5, OPC_R));    // and
        prog.push_back(i_type(int'(k), 1, 3, 6, OPC_I)); // sltiu
        prog.push_back(i_type(5, 1, 5, 7, OPC_I));       // srli 5
        prog.push_back(i_type(int'(m), 2, 7, 8, OPC_I)); // andi
        for (int r = 3; r <= 8; r++) begin
            prog.push_back(s_type(256 + 8 * (r - 3), r, 0, 3));
        end
        prog.push_back(EBREAK);
        exp_val[0] = a + b;
        exp_val[1] = a - b;
        exp_val[2] = a & b;
        exp_val[3] = (a < imm_to_64(k)) ? 64'd1 : 64'd0;
        exp_val[4] = a >> 5;
        exp_val[5] = b & imm_to_64(m);
        start_core();
        wait_done();
        for (int n = 0; n < 6; n++) begin
            check($sformatf("dmem[0x%0h]", 256 + 8 * n), dmem[32 + n], exp_val[n]);
        end
        report_test("arithmetic", err0);
    endtask

    task automatic word_test();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] s;
        logic [63:0] c;
        logic [11:0] n;
        int          err0;
        err0 = errors;
        prepare_memories();
        load_const(1, 32'h7fff_f400 | ($urandom() & 32'h3ff), a);
        load_const(2, 32'h4000_0000 | ($urandom() & 32'h0fff_ffff), b);
        s = 64'(32 + $urandom() % 32); // bit 5 set, ignored by sllw
        n = 12'h800 | 12'($urandom());
        prog.push_back(i_type(int'(s), 0, 0, 5, OPC_I));
        prog.push_back(u_type(20'h80000, 7, OPC_LUI));
        c = word_to_64(32'h8000_0000);
        prog.push_back(r_type(0, 2, 1, 0, 3, OPC_RW));   // addw
        prog.push_back(r_type(0, 5, 1, 1, 4, OPC_RW));   // sllw
        prog.push_back(i_type(int'(n), 7, 0, 6, OPC_IW)); // addiw
        prog.push_back(s_type(256, 3, 0, 3));
        prog.push_back(s_type(264, 4, 0, 3));
        prog.push_back(s_type(272, 6, 0, 3));
        prog.push_back(EBREAK);
        start_core();
        wait_done();
        check("addw result", dmem[32], word_to_64(a[31:0] + b[31:0]));
        check("sllw result", dmem[33], word_to_64(a[31:0] << s[4:0]));
        check("addiw result", dmem[34], word_to_64(c[31:0] + n_ext(n)));
        report_test("word ops", err0);
    endtask

    function automatic logic [31:0] n_ext(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic load_store_test();
        logic [63:0] v;
        logic [63:0] s;
        logic [63:0] f;
        int          err0;
        err0 = errors;
        prepare_memories();
        v = {1'b0, 31'($urandom()), 32'($urandom()) | 32'h8000_8000}; // negative word, byte > 0x7f
        dmem_init[32] = v;
        f = fill_word(52);
        prog.push_back(i_type(256, 0, 2, 1, OPC_LOAD)); // lw
        prog.push_back(i_type(257, 0, 4, 2, OPC_LOAD)); // lbu
        prog.push_back(i_type(256, 0, 3, 3, OPC_LOAD)); // ld
        prog.push_back(i_type(260, 0, 2, 4, OPC_LOAD)); // lw upper word
        load_const(5, $urandom(), s);
        for (int r = 1; r <= 4; r++) begin
            prog.push_back(s_type(384 + 8 * (r - 1), r, 0, 3));
        end
        prog.push_back(s_type(418, 5, 0, 1));           // sh to 0x1a2
        prog.push_back(EBREAK);
        start_core();
        wait_done();
        check("lw result", dmem[48], word_to_64(v[31:0]));
        check("lbu result", dmem[49], {56'b0, v[15:8]});
        check("ld result", dmem[50], v);
        check("lw upper result", dmem[51], word_to_64(v[63:32]));
        check("sh doubleword", dmem[52], {f[63:32], s[15:0], f[15:0]});
        report_test("loads and stores", err0);
    endtask

    task automatic branch_jump_test();
        logic [19:0] u;
        logic [63:0] auipc_pc;
        int          err0;
        err0 = errors;
        prepare_memories();
        u = 20'($urandom());
        prog.push_back(i_type(5, 0, 0, 1, OPC_I));
        prog.push_back(i_type(5, 0, 0, 2, OPC_I));
        prog.push_back(i_type(7, 0, 0, 3, OPC_I));
        prog.push_back(i_type(1, 0, 0, 9, OPC_I));     // marker
        prog.push_back(b_type(8, 2, 1, 0));            // beq taken
        prog.push_back(s_type(256, 9, 0, 3));
        prog.push_back(b_type(8, 3, 1, 0));            // beq not taken
        prog.push_back(s_type(264, 9, 0, 3));
        prog.push_back(b_type(8, 3, 1, 1));            // bne taken
        prog.push_back(s_type(272, 9, 0, 3));
        prog.push_back(b_type(8, 2, 1, 1));            // bne not taken
        prog.push_back(s_type(280, 9, 0, 3));
        prog.push_back(j_type(8, 10));                 // at 48, link 52
        prog.push_back(s_type(288, 9, 0, 3));
        prog.push_back(i_type(71, 0, 0, 11, OPC_I));
        prog.push_back(i_type(2, 11, 0, 12, OPC_JALR)); // at 60, target 73 -> 72
        prog.push_back(s_type(296, 9, 0, 3));
        prog.push_back(s_type(304, 9, 0, 3));
        auipc_pc = 64'(prog.size() * 4);
        prog.push_back(u_type(u, 13, OPC_AUIPC));
        prog.push_back(s_type(312, 10, 0, 3));
        prog.push_back(s_type(320, 12, 0, 3));
        prog.push_back(s_type(328, 13, 0, 3));
        prog.push_back(EBREAK);
        start_core();
        wait_done();
        check("beq taken skip", dmem[32], fill_word(32));
        check("beq not taken store", dmem[33], 64'd1);
        check("bne taken skip", dmem[34], fill_word(34));
        check("bne not taken store", dmem[35], 64'd1);
        check("jal skip", dmem[36], fill_word(36));
        check("jalr skip 1", dmem[37], fill_word(37));
        check("jalr skip 2", dmem[38], fill_word(38));
        check("jal link", dmem[39], 64'd52);
        check("jalr link", dmem[40], 64'd64);
        check("auipc result", dmem[41], auipc_pc + word_to_64({u, 12'b0}));
        report_test("control flow", err0);
    endtask

    task automatic halt_illegal_test();
        int err0;
        err0 = errors;
        prepare_memories();
        prog.push_back(i_type(85, 0, 0, 1, OPC_I));
        prog.push_back(EBREAK);
        prog.push_back(s_type(256, 1, 0, 3));          // must never run
        start_core();
        @(negedge clk);
        check("halt after reset", 64'(halt), 64'h0);
        check("illegal after reset", 64'(illegal), 64'h0);
        wait_done();
        @(posedge clk);
        #2 imem[1] = s_type(256, 1, 0, 3);            // store shows up at the halted pc
        repeat (5) @(negedge clk);
        check("halt", 64'(halt), 64'h1);
        check("illegal", 64'(illegal), 64'h0);
        check("imem_addr after ebreak", imem_addr, 64'd4);
        check("dmem_wen after ebreak", 64'(dmem_wen), 64'h0);
        check("dmem[0x100]", dmem[32], fill_word(32));
        prepare_memories();
        prog.push_back(i_type(102, 0, 0, 1, OPC_I));
        prog.push_back(r_type(1, 1, 1, 0, 2, OPC_R));  // mul
        prog.push_back(s_type(264, 1, 0, 3));
        prog.push_back(EBREAK);
        start_core();
        wait_done();
        repeat (5) @(negedge clk);
        check("illegal", 64'(illegal), 64'h1);
        check("halt", 64'(halt), 64'h0);
        check("imem_addr after mul", imem_addr, 64'd4);
        check("dmem[0x108]", dmem[33], fill_word(33));
        report_test("halt and illegal", err0);
    endtask

    initial begin
        void'($urandom(32'h1eb1));
        clk    = 1'b0;
        rst_n  = 1'b0;
        errors = 0;
        checks = 0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = unused_inst(i);
        end
        prepare_memories();
        arith_test();
        word_test();
        load_store_test();
        branch_jump_test();
        halt_illegal_test();
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", NUM_TESTS * 200);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== src.f ====
rtl/rvseed_pkg.sv
rtl/ctrl.sv
rtl/imm_gen.sv
rtl/alu.sv
rtl/regfile.sv
rtl/rvseed_core.sv
tests/tb_rvseed_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rvseed_core -f src.f -o sim_rvseed \
    && ./obj_dir/sim_rvseed | tee /dev/stderr \
        | grep -F "Test completed successfully" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }
